//--- source/dbus_interconnect.sv
`timescale 1ns/100ps
`default_nettype none

module dbus_interconnect #(
    parameter int GPIO_BANKS = 4                            // Number of GPIO banks
) (
    input  wire                                     clk,            // Clock
    input  wire                                     rst_n_i,        // Async reset, active low

    // Core request side
    input  wire                                     dbus_req_i,     // Request level
    input  wire dbus_pkg::type_dbus_addr_u          dbus_addr_i,    // Held until ack

    // Target selects
    output logic                                    dmem_sel_o,
    output logic [GPIO_BANKS-1:0]                   gpio_sel_o,     // One strobe per bank

    // Response to the core
    output logic [dbus_pkg::XLEN-1:0]               dbus_rdata_o,
    output logic                                    dbus_ack_o,

    // Responses from the targets
    input  wire  [dbus_pkg::XLEN-1:0]               dmem_rdata_i,
    input  wire                                     dmem_ack_i,
    input  wire  [GPIO_BANKS*dbus_pkg::XLEN-1:0]    gpio_rdata_i,   // Bank 0 in low slice
    input  wire  [GPIO_BANKS-1:0]                   gpio_ack_i
);

    logic dmem_hit;   // Address in the memory region
    logic gpio_hit;   // Address in the GPIO region and bank present

    // Region match on the raw word
    assign dmem_hit = (dbus_addr_i.raw & dbus_pkg::DMEM_ADDR_MASK) == dbus_pkg::DMEM_ADDR_MATCH;

    // GPIO region, bank index beyond the last bank is unmapped
    assign gpio_hit = ((dbus_addr_i.raw & dbus_pkg::GPIO_ADDR_MASK) == dbus_pkg::GPIO_ADDR_MATCH)
                   && (int'(dbus_addr_i.gpio.bank) < GPIO_BANKS);

    assign dmem_sel_o = dbus_req_i & dmem_hit;     // Gated by the request

    // Bank strobe from the bank index field
    always_comb begin
        for (int b = 0; b < GPIO_BANKS; b++) begin
            gpio_sel_o[b] = dbus_req_i && gpio_hit && (int'(dbus_addr_i.gpio.bank) == b);
        end
    end

    // Read-response mux
    // Address is still held in the ack cycle, so the select picks the right reply
    always_comb begin
        dbus_rdata_o = '0;                         // Unmapped gives zero
        dbus_ack_o   = 1'b0;                       // and never an ack
        if (dmem_sel_o) begin
            dbus_rdata_o = dmem_rdata_i;
            dbus_ack_o   = dmem_ack_i;
        end
        for (int b = 0; b < GPIO_BANKS; b++) begin
            if (gpio_sel_o[b]) begin
                dbus_rdata_o = gpio_rdata_i[b*dbus_pkg::XLEN +: dbus_pkg::XLEN];
                dbus_ack_o   = gpio_ack_i[b];
            end
        end
    end

    // At most one target selected at any time
    a_sel_onehot : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $onehot0({dmem_sel_o, gpio_sel_o})
    ) else $error("dbus_interconnect: more than one target selected");

    // Targets only answer a request that was already present the cycle before
    a_ack_has_req : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        dbus_ack_o |-> (dbus_req_i && $past(dbus_req_i))
    ) else $error("dbus_interconnect: acknowledge without a pending request");

endmodule : dbus_interconnect

`default_nettype wire

//--- source/dbus_pkg.sv
`default_nettype none

package dbus_pkg;

    // Bus widths
    localparam int XLEN = 32;                      // Address and data word
    localparam int BE_W = XLEN / 8;                // One enable per byte lane

    // Address map, region picked by the top nibble
    localparam logic [XLEN-1:0] DMEM_ADDR_MASK  = 32'hF000_0000;
    localparam logic [XLEN-1:0] DMEM_ADDR_MATCH = 32'h1000_0000;  // 0x1xxx_xxxx
    localparam logic [XLEN-1:0] GPIO_ADDR_MASK  = 32'hF000_0000;
    localparam logic [XLEN-1:0] GPIO_ADDR_MATCH = 32'h8000_0000;  // 0x8xxx_xxxx

    // GPIO field widths
    localparam int GPIO_BANK_IDX_W = 4;            // Bank index field
    localparam int GPIO_MAX_BANKS  = 2 ** GPIO_BANK_IDX_W;
    localparam int GPIO_REG_IDX_W  = 2;            // Register index field
    localparam int GPIO_RSVD_W     = 20;           // Bits 27:8

    // GPIO register indices
    localparam logic [GPIO_REG_IDX_W-1:0] GPIO_REG_OUT = 2'd0;  // Output value
    localparam logic [GPIO_REG_IDX_W-1:0] GPIO_REG_DIR = 2'd1;  // Output enable
    localparam logic [GPIO_REG_IDX_W-1:0] GPIO_REG_IN  = 2'd2;  // Synchronised pins
    // Index 3 is a hole and reads back as zero

    // One bus address word, seen either raw or as GPIO fields
    typedef union packed {
        logic [XLEN-1:0] raw;                      // Decoder and memory view
        struct packed {
            logic [3:0]                 region;    // [31:28]
            logic [GPIO_RSVD_W-1:0]     rsvd;      // [27:8] unused
            logic [GPIO_BANK_IDX_W-1:0] bank;      // [7:4]
            logic [GPIO_REG_IDX_W-1:0]  reg_idx;   // [3:2]
            logic [1:0]                 byte_off;  // [1:0] word aligned only
        } gpio;
    } type_dbus_addr_u;

endpackage : dbus_pkg

`default_nettype wire

//--- source/dbus_subsys_top.sv
`timescale 1ns/100ps
`default_nettype none

module dbus_subsys_top #(
    parameter int DMEM_DEPTH = 256,                         // Memory words
    parameter int GPIO_BANKS = 4,                           // Up to 16
    parameter int GPIO_WIDTH = 8                            // Up to XLEN
) (
    input  wire                                 clk,            // Clock
    input  wire                                 rst_n_i,        // Async reset, active low

    // Core data bus
    input  wire                                 dbus_req_i,
    input  wire                                 dbus_we_i,
    input  wire  [dbus_pkg::BE_W-1:0]           dbus_be_i,
    input  wire  [dbus_pkg::XLEN-1:0]           dbus_addr_i,    // Raw address word
    input  wire  [dbus_pkg::XLEN-1:0]           dbus_wdata_i,
    output logic [dbus_pkg::XLEN-1:0]           dbus_rdata_o,
    output logic                                dbus_ack_o,

    // GPIO pins, bank 0 in the low slice
    input  wire  [GPIO_BANKS*GPIO_WIDTH-1:0]    gpio_in_i,
    output logic [GPIO_BANKS*GPIO_WIDTH-1:0]    gpio_out_o,
    output logic [GPIO_BANKS*GPIO_WIDTH-1:0]    gpio_oe_o
);

    dbus_pkg::type_dbus_addr_u                  dbus_addr;      // Shared address view
    logic                                       dmem_sel;
    logic [dbus_pkg::XLEN-1:0]                  dmem_rdata;
    logic                                       dmem_ack;
    logic [GPIO_BANKS-1:0]                      gpio_sel;
    logic [GPIO_BANKS*dbus_pkg::XLEN-1:0]       gpio_rdata;     // Packed bank replies
    logic [GPIO_BANKS-1:0]                      gpio_ack;

    // Parameter range checks at elaboration
    if (GPIO_BANKS < 1 || GPIO_BANKS > dbus_pkg::GPIO_MAX_BANKS) begin : g_chk_banks
        $error("dbus_subsys_top: GPIO_BANKS out of range");
    end
    if (GPIO_WIDTH < 1 || GPIO_WIDTH > dbus_pkg::XLEN) begin : g_chk_width
        $error("dbus_subsys_top: GPIO_WIDTH out of range");
    end

    assign dbus_addr.raw = dbus_addr_i;

    // Decoder and response mux
    dbus_interconnect #(
        .GPIO_BANKS   (GPIO_BANKS)
    ) u_dbus_interconnect (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .dbus_req_i   (dbus_req_i),
        .dbus_addr_i  (dbus_addr),
        .dmem_sel_o   (dmem_sel),
        .gpio_sel_o   (gpio_sel),
        .dbus_rdata_o (dbus_rdata_o),
        .dbus_ack_o   (dbus_ack_o),
        .dmem_rdata_i (dmem_rdata),
        .dmem_ack_i   (dmem_ack),
        .gpio_rdata_i (gpio_rdata),
        .gpio_ack_i   (gpio_ack)
    );

    // Data memory
    dmem_ram #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) u_dmem_ram (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .sel_i      (dmem_sel),
        .we_i       (dbus_we_i),
        .be_i       (dbus_be_i),
        .addr_i     (dbus_addr),
        .wdata_i    (dbus_wdata_i),
        .rdata_o    (dmem_rdata),
        .ack_o      (dmem_ack)
    );

    // GPIO banks, one slice of each bus per bank
    for (genvar b = 0; b < GPIO_BANKS; b++) begin : g_gpio
        gpio_bank #(
            .GPIO_WIDTH (GPIO_WIDTH)
        ) u_gpio_bank (
            .clk        (clk),
            .rst_n_i    (rst_n_i),
            .sel_i      (gpio_sel[b]),
            .we_i       (dbus_we_i),
            .addr_i     (dbus_addr),
            .wdata_i    (dbus_wdata_i),
            .rdata_o    (gpio_rdata[b*dbus_pkg::XLEN +: dbus_pkg::XLEN]),
            .ack_o      (gpio_ack[b]),
            .pin_i      (gpio_in_i[b*GPIO_WIDTH +: GPIO_WIDTH]),
            .pin_o      (gpio_out_o[b*GPIO_WIDTH +: GPIO_WIDTH]),
            .oe_o       (gpio_oe_o[b*GPIO_WIDTH +: GPIO_WIDTH])
        );
    end

endmodule : dbus_subsys_top

`default_nettype wire

//--- source/dmem_ram.sv
`timescale 1ns/100ps
`default_nettype none

module dmem_ram #(
    parameter int DMEM_DEPTH = 256                          // Depth in words
) (
    input  wire                                 clk,        // Clock
    input  wire                                 rst_n_i,    // Async reset, active low

    input  wire                                 sel_i,      // From the decoder
    input  wire                                 we_i,       // Write enable
    input  wire  [dbus_pkg::BE_W-1:0]           be_i,       // Byte enables
    input  wire dbus_pkg::type_dbus_addr_u      addr_i,     // Raw view used here
    input  wire  [dbus_pkg::XLEN-1:0]           wdata_i,

    output logic [dbus_pkg::XLEN-1:0]           rdata_o,    // Valid with ack_o
    output logic                                ack_o       // One cycle pulse
);

    // Word index width, at least one bit
    localparam int AW = (DMEM_DEPTH > 1) ? $clog2(DMEM_DEPTH) : 1;

    logic [dbus_pkg::XLEN-1:0] mem [DMEM_DEPTH];   // Word array
    logic [AW-1:0]             word_idx;           // Wrapped word address
    logic                      access;             // Serve this cycle

    // Drop the byte offset and wrap into the array
    assign word_idx = AW'(addr_i.raw[dbus_pkg::XLEN-1:2] % DMEM_DEPTH);

    // First cycle of a selected request
    // Blocked in the ack cycle so a held request is served once
    assign access = sel_i & ~ack_o;

    // Acknowledge register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= access;                       // Rises one cycle after the request
        end
    end

    // Array write and registered read
    always_ff @(posedge clk) begin
        if (access) begin
            rdata_o <= mem[word_idx];              // Old word on a write
            if (we_i) begin
                for (int i = 0; i < dbus_pkg::BE_W; i++) begin
                    if (be_i[i]) begin
                        mem[word_idx][i*8 +: 8] <= wdata_i[i*8 +: 8];   // Enabled lanes only
                    end
                end
            end
        end
    end

    // Never two acks back to back
    a_ack_gap : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        ack_o |=> !ack_o
    ) else $error("dmem_ram: acknowledge high in two consecutive cycles");

endmodule : dmem_ram

`default_nettype wire

//--- source/gpio_bank.sv
`timescale 1ns/100ps
`default_nettype none

module gpio_bank #(
    parameter int GPIO_WIDTH = 8                            // Pins in this bank
) (
    input  wire                                 clk,        // Clock
    input  wire                                 rst_n_i,    // Async reset, active low

    input  wire                                 sel_i,      // Bank strobe
    input  wire                                 we_i,       // Write enable
    input  wire dbus_pkg::type_dbus_addr_u      addr_i,     // GPIO field view used here
    input  wire  [dbus_pkg::XLEN-1:0]           wdata_i,    // Low bits used

    output logic [dbus_pkg::XLEN-1:0]           rdata_o,    // Valid with ack_o
    output logic                                ack_o,      // One cycle pulse

    input  wire  [GPIO_WIDTH-1:0]               pin_i,      // Asynchronous pins
    output logic [GPIO_WIDTH-1:0]               pin_o,      // Output values
    output logic [GPIO_WIDTH-1:0]               oe_o        // Output enables
);

    logic [GPIO_WIDTH-1:0]     out_q;              // Output register
    logic [GPIO_WIDTH-1:0]     dir_q;              // Direction register, 1 drives
    logic [GPIO_WIDTH-1:0]     sync_q1;            // First sync stage
    logic [GPIO_WIDTH-1:0]     sync_q2;            // Input register
    logic [dbus_pkg::XLEN-1:0] reg_rdata;          // Addressed register, zero-extended
    logic                      access;             // Serve this cycle
    logic                      wr_en;              // Register write strobe

    assign access = sel_i & ~ack_o;                // One service per request
    assign wr_en  = access & we_i;

    // Register read mux
    always_comb begin
        case (addr_i.gpio.reg_idx)
            dbus_pkg::GPIO_REG_OUT: reg_rdata = dbus_pkg::XLEN'(out_q);
            dbus_pkg::GPIO_REG_DIR: reg_rdata = dbus_pkg::XLEN'(dir_q);
            dbus_pkg::GPIO_REG_IN:  reg_rdata = dbus_pkg::XLEN'(sync_q2);
            default:                reg_rdata = '0;     // Hole at index 3
        endcase
    end

    // Control registers and ack
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
            out_q <= '0;                           // Pins low
            dir_q <= '0;                           // All inputs
        end else begin
            ack_o <= access;
            if (wr_en) begin
                case (addr_i.gpio.reg_idx)
                    dbus_pkg::GPIO_REG_OUT: out_q <= wdata_i[GPIO_WIDTH-1:0];
                    dbus_pkg::GPIO_REG_DIR: dir_q <= wdata_i[GPIO_WIDTH-1:0];
                    default: ;                     // IN and hole are read only
                endcase
            end
        end
    end

    // Pin synchroniser and read data
    always_ff @(posedge clk) begin
        sync_q1 <= pin_i;
        sync_q2 <= sync_q1;                        // Visible two cycles after sampling
        if (access) begin
            rdata_o <= reg_rdata;
        end
    end

    assign pin_o = out_q;
    assign oe_o  = dir_q;

    // Writing the input index leaves the pin drivers alone
    a_in_write_ignored : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (wr_en && (addr_i.gpio.reg_idx == dbus_pkg::GPIO_REG_IN))
            |=> ($stable(out_q) && $stable(dir_q))
    ) else $error("gpio_bank: write to input register changed output or direction");

endmodule : gpio_bank

`default_nettype wire

//--- verification/dbus_checker.sv
`timescale 1ns/100ps
`default_nettype none

module dbus_checker #(
    parameter int DMEM_DEPTH = 256,
    parameter int GPIO_BANKS = 4,
    parameter int GPIO_WIDTH = 8
) (
    input  wire                                 clk,
    input  wire                                 rst_n_i,
    input  wire                                 dbus_req_i,
    input  wire                                 dbus_we_i,
    input  wire  [3:0]                          dbus_be_i,
    input  wire  [31:0]                         dbus_addr_i,
    input  wire  [31:0]                         dbus_wdata_i,
    input  wire  [31:0]                         dbus_rdata_i,   // DUT response
    input  wire                                 dbus_ack_i,
    input  wire  [GPIO_BANKS*GPIO_WIDTH-1:0]    gpio_in_i,
    input  wire  [GPIO_BANKS*GPIO_WIDTH-1:0]    gpio_out_i,
    input  wire  [GPIO_BANKS*GPIO_WIDTH-1:0]    gpio_oe_i,
    input  wire  [2:0]                          test_id_i,      // Test now running
    input  wire                                 tests_done_i,   // Stimulus finished
    output int                                  error_count_o,
    output logic                                report_done_o   // Closing line printed
);

    localparam int PINS = GPIO_BANKS * GPIO_WIDTH;

    logic [31:0]     mem_model [DMEM_DEPTH];       // Written bytes per word
    logic [3:0]      mem_known [DMEM_DEPTH];       // Lanes written so far
    logic [PINS-1:0] out_model;                    // Expected gpio_out_o
    logic [PINS-1:0] dir_model;                    // Expected gpio_oe_o
    logic            prev_req;
    logic            prev_ack;
    logic            seen_req;                     // First request seen after reset
    logic            finished;
    int              age;                          // Sampled cycles of the held request
    int              cur_test     = 0;
    int              tests_closed = 0;
    int              total_checks = 0;
    int              total_errors = 0;
    int              test_checks  = 0;
    int              test_errors  = 0;

    assign error_count_o = total_errors;

    function automatic string test_name(input int id);
        case (id)
            1:       return "reset_state";
            2:       return "dmem_random";
            3:       return "gpio_regs";
            4:       return "gpio_input";
            5:       return "unmapped";
            default: return "idle";
        endcase
    endfunction

    // Compare one value, mismatch line on failure
    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        total_checks++;
        test_checks++;
        if (act !== exp) begin
            $display("Mismatch in %s: %s expected 0x%08h actual 0x%08h",
                     test_name(cur_test), what, exp, act);
            total_errors++;
            test_errors++;
        end
    endtask

    // Protocol errors that have no value to compare
    task automatic report_failure(input string text);
        total_checks++;
        test_checks++;
        total_errors++;
        test_errors++;
        $display("Error in %s: %s at %0t ns", test_name(cur_test), text, $time);
    endtask

    task automatic close_test();
        if (cur_test != 0) begin
            $display("Test %s done: %0d checks, %0d errors",
                     test_name(cur_test), test_checks, test_errors);
            tests_closed++;
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    // Acknowledged access, update or compare against the model
    task automatic check_response();
        int          idx;
        int          bank;
        logic [31:0] mask;
        logic [31:0] exp;
        idx  = (dbus_addr_i >> 2) % DMEM_DEPTH;    // Word index wraps
        bank = dbus_addr_i[7:4];
        mask = '0;
        exp  = '0;
        if (dbus_addr_i[31:28] == 4'h1) begin
            for (int l = 0; l < 4; l++) begin
                if (dbus_we_i && dbus_be_i[l]) begin
                    mem_model[idx][l*8 +: 8] = dbus_wdata_i[l*8 +: 8];
                    mem_known[idx][l]        = 1'b1;
                end
                mask[l*8 +: 8] = {8{mem_known[idx][l]}};   // Untouched lanes ignored
            end
            if (!dbus_we_i) begin
                check_value($sformatf("dmem read 0x%08h", dbus_addr_i),
                            mem_model[idx] & mask, dbus_rdata_i & mask);
            end
        end else if (dbus_we_i) begin
            case (dbus_addr_i[3:2])
                2'd0:    out_model[bank*GPIO_WIDTH +: GPIO_WIDTH] = dbus_wdata_i[GPIO_WIDTH-1:0];
                2'd1:    dir_model[bank*GPIO_WIDTH +: GPIO_WIDTH] = dbus_wdata_i[GPIO_WIDTH-1:0];
                default: ;                         // Input reg and hole keep state
            endcase
            check_value("gpio_out_o after write", out_model, gpio_out_i);
            check_value("gpio_oe_o after write", dir_model, gpio_oe_i);
        end else begin
            case (dbus_addr_i[3:2])
                2'd0:    exp = out_model[bank*GPIO_WIDTH +: GPIO_WIDTH];
                2'd1:    exp = dir_model[bank*GPIO_WIDTH +: GPIO_WIDTH];
                2'd2:    exp = gpio_in_i[bank*GPIO_WIDTH +: GPIO_WIDTH];   // Pins held stable
                default: exp = '0;
            endcase
            check_value($sformatf("gpio bank %0d reg %0d read", bank, dbus_addr_i[3:2]),
                        exp, dbus_rdata_i);
        end
    endtask

    // Sampled at the rising edge, inputs were driven at the edge before
    always @(posedge clk) begin : watch
        logic mapped;
        logic new_req;
        if (!rst_n_i) begin
            prev_req      = 1'b0;
            prev_ack      = 1'b0;
            seen_req      = 1'b0;
            finished      = 1'b0;
            age           = 0;
            out_model     = '0;                    // Pins reset low
            dir_model     = '0;
            report_done_o <= 1'b0;
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                mem_known[i] = '0;
                mem_model[i] = '0;
            end
        end else begin
            if (int'(test_id_i) != cur_test) begin
                close_test();
                cur_test = test_id_i;
            end
            mapped  = (dbus_addr_i[31:28] == 4'h1)
                   || ((dbus_addr_i[31:28] == 4'h8) && (dbus_addr_i[7:4] < GPIO_BANKS));
            new_req = dbus_req_i && (!prev_req || prev_ack);
            if (!dbus_req_i) begin
                age = 0;
            end else if (new_req) begin
                age = 1;
            end else begin
                age = age + 1;
            end
            // Quiet outputs between reset and the first request
            if (cur_test == 1 && !seen_req && !dbus_req_i) begin
                check_value("dbus_ack_o after reset", 32'd0, dbus_ack_i);
                check_value("gpio_out_o after reset", 32'd0, gpio_out_i);
                check_value("gpio_oe_o after reset", 32'd0, gpio_oe_i);
            end
            if (dbus_req_i) begin
                seen_req = 1'b1;
            end
            if (dbus_ack_i) begin
                if (dbus_req_i && mapped && age == 2) begin
                    check_response();
                end else begin
                    report_failure($sformatf("unexpected acknowledge, address 0x%08h",
                                             dbus_addr_i));
                end
            end else if (dbus_req_i && mapped && age == 2) begin
                report_failure($sformatf("no acknowledge one cycle after request to 0x%08h",
                                         dbus_addr_i));
            end
            if (dbus_req_i && !mapped) begin
                check_value("rdata on unmapped address", 32'd0, dbus_rdata_i);
            end
            if (tests_done_i && !finished) begin
                close_test();
                $display("Tests: %0d, checks: %0d, errors: %0d",
                         tests_closed, total_checks, total_errors);
                finished      = 1'b1;
                report_done_o <= 1'b1;
            end
            prev_req = dbus_req_i;
            prev_ack = dbus_ack_i;
        end
    end

endmodule : dbus_checker

`default_nettype wire

//--- verification/tb_dbus_subsys.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dbus_subsys;

    localparam int GPIO_BANKS = 4;                 // DUT defaults
    localparam int GPIO_WIDTH = 8;
    localparam int DMEM_DEPTH = 256;
    localparam int PINS       = GPIO_BANKS * GPIO_WIDTH;

    // Loop lengths of the tests
    localparam int DMEM_PAIRS      = 200;          // Write then read
    localparam int GPIO_PAIRS      = 60;           // Write then read
    localparam int GPIO_IN_READS   = 16;
    localparam int UNMAPPED_ROUNDS = 20;           // Unmapped hold then mapped read

    localparam int NUM_REQUESTS = 2 + 2 * DMEM_PAIRS + 2 * GPIO_PAIRS + GPIO_IN_READS
                                + 2 * UNMAPPED_ROUNDS;
    localparam int CYCLE_LIMIT  = NUM_REQUESTS * 6 + 50;

    logic            clk;
    logic            rst_n_i;
    logic            dbus_req_i;
    logic            dbus_we_i;
    logic [3:0]      dbus_be_i;
    logic [31:0]     dbus_addr_i;
    logic [31:0]     dbus_wdata_i;
    logic [31:0]     dbus_rdata_o;
    logic            dbus_ack_o;
    logic [PINS-1:0] gpio_in_i;
    logic [PINS-1:0] gpio_out_o;
    logic [PINS-1:0] gpio_oe_o;
    logic [2:0]      test_id;
    logic            tests_done;
    logic            report_done;
    int              err_count;
    int              cycle_cnt = 0;

    dbus_subsys_top UUT (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .dbus_req_i   (dbus_req_i),
        .dbus_we_i    (dbus_we_i),
        .dbus_be_i    (dbus_be_i),
        .dbus_addr_i  (dbus_addr_i),
        .dbus_wdata_i (dbus_wdata_i),
        .dbus_rdata_o (dbus_rdata_o),
        .dbus_ack_o   (dbus_ack_o),
        .gpio_in_i    (gpio_in_i),
        .gpio_out_o   (gpio_out_o),
        .gpio_oe_o    (gpio_oe_o)
    );

    dbus_checker #(
        .DMEM_DEPTH (DMEM_DEPTH),
        .GPIO_BANKS (GPIO_BANKS),
        .GPIO_WIDTH (GPIO_WIDTH)
    ) u_dbus_checker (
        .clk (clk), .rst_n_i (rst_n_i),
        .dbus_req_i (dbus_req_i), .dbus_we_i (dbus_we_i), .dbus_be_i (dbus_be_i),
        .dbus_addr_i (dbus_addr_i), .dbus_wdata_i (dbus_wdata_i),
        .dbus_rdata_i (dbus_rdata_o), .dbus_ack_i (dbus_ack_o),
        .gpio_in_i (gpio_in_i), .gpio_out_i (gpio_out_o), .gpio_oe_i (gpio_oe_o),
        .test_id_i (test_id), .tests_done_i (tests_done),
        .error_count_o (err_count), .report_done_o (report_done)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;                          // 4 ns period

    // Run limit from the request budget
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, a request was never acknowledged", cycle_cnt);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Starts and returns right after a rising edge
    task automatic issue_request(input logic we, input logic [3:0] be,
                                 input logic [31:0] addr, input logic [31:0] wdata);
        dbus_req_i   <= 1'b1;
        dbus_we_i    <= we;
        dbus_be_i    <= be;
        dbus_addr_i  <= addr;
        dbus_wdata_i <= wdata;
        @(posedge clk);
        while (!dbus_ack_o) begin
            @(posedge clk);                        // Hold until acknowledged
        end
        dbus_req_i <= 1'b0;
        dbus_we_i  <= 1'b0;
        @(posedge clk);                            // Idle gap
    endtask

    // Held 4 cycles with no ack expected
    task automatic hold_unmapped(input logic [31:0] addr);
        dbus_req_i   <= 1'b1;
        dbus_we_i    <= 1'($urandom);
        dbus_be_i    <= 4'hF;
        dbus_addr_i  <= addr;
        dbus_wdata_i <= $urandom;
        repeat (4) @(posedge clk);
        dbus_req_i <= 1'b0;
        dbus_we_i  <= 1'b0;
        @(posedge clk);
    endtask

    function automatic logic [31:0] dmem_addr();
        return {4'h1, 26'($urandom), 2'b00};      // Word aligned in region 0x1
    endfunction

    function automatic logic [31:0] gpio_addr(input int bank, input int regi);
        return {4'h8, 20'h0, 4'(bank), 2'(regi), 2'b00};
    endfunction

    function automatic logic [31:0] unmapped_addr();
        logic [31:0] a;
        a = $urandom;
        if (a[0]) begin
            a[31:28] = 4'h8;                       // GPIO region with a missing bank
            a[7:4]   = 4'(GPIO_BANKS + ($urandom % (16 - GPIO_BANKS)));
        end else begin
            while (a[31:28] == 4'h1 || a[31:28] == 4'h8) begin
                a[31:28] = 4'($urandom);
            end
        end
        return a;
    endfunction

    initial begin : stimulus
        logic [31:0] addr;
        logic [31:0] written [$];                  // Write history for read hits
        void'($urandom(32'h4329_c2fa));            // Seed the stimulus once
        rst_n_i      <= 1'b0;
        dbus_req_i   <= 1'b0;
        dbus_we_i    <= 1'b0;
        dbus_be_i    <= 4'h0;
        dbus_addr_i  <= '0;
        dbus_wdata_i <= '0;
        gpio_in_i    <= PINS'($urandom);
        test_id      <= 3'd1;
        tests_done   <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n_i <= 1'b1;
        repeat (3) @(posedge clk);                 // Outputs watched while idle
        addr = dmem_addr();
        issue_request(1'b1, 4'hF, addr, $urandom);
        issue_request(1'b0, 4'hF, addr, '0);

        test_id <= 3'd2;
        for (int i = 0; i < DMEM_PAIRS; i++) begin
            addr = dmem_addr();
            written.push_back(addr);
            issue_request(1'b1, 4'($urandom), addr, $urandom);
            addr = written[$urandom % written.size()];
            issue_request(1'b0, 4'hF, addr, '0);
        end

        test_id <= 3'd3;
        for (int i = 0; i < GPIO_PAIRS; i++) begin
            addr = gpio_addr($urandom % GPIO_BANKS, $urandom % 4);
            issue_request(1'b1, 4'hF, addr, $urandom);
            issue_request(1'b0, 4'hF, addr, '0);
        end

        test_id <= 3'd4;
        for (int i = 0; i < GPIO_IN_READS; i++) begin
            gpio_in_i <= PINS'($urandom);
            repeat (3) @(posedge clk);             // Through the synchroniser
            addr = gpio_addr($urandom % GPIO_BANKS, dbus_pkg::GPIO_REG_IN);
            issue_request(1'b0, 4'hF, addr, '0);
        end

        test_id <= 3'd5;
        for (int i = 0; i < UNMAPPED_ROUNDS; i++) begin
            hold_unmapped(unmapped_addr());
            addr = written[$urandom % written.size()];   // Known bytes to compare
            issue_request(1'b0, 4'hF, addr, '0);
        end

        tests_done <= 1'b1;
        @(posedge clk);
        while (!report_done) begin
            @(posedge clk);
        end
        if (err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : tb_dbus_subsys

`default_nettype wire

//--- vlog.f
source/dbus_pkg.sv
source/dbus_interconnect.sv
source/dmem_ram.sv
source/gpio_bank.sv
source/dbus_subsys_top.sv
verification/dbus_checker.sv
verification/tb_dbus_subsys.sv
